/* source/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_XLEN        32
`define RV_WB_SEL_W    4

`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011

// ALU operations, shared by OP and OP-IMM.
`define RV_F3_ADD      3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SR       3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

`define RV_F3_BEQ      3'b000
`define RV_F3_BNE      3'b001
`define RV_F3_BLT      3'b100
`define RV_F3_BGE      3'b101
`define RV_F3_BLTU     3'b110
`define RV_F3_BGEU     3'b111

`endif

/* source/rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

typedef struct packed {
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
} issue_t;

typedef struct packed {
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                modifier;   // Selects SUB or SRA.
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic                mem;
    logic                store;
    logic                we;
} decoded_t;

typedef struct packed {
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] value;      // ALU result or link address.
    logic                we;
    logic                mem;
    logic                store;
    logic [`RV_XLEN-1:0] adr;
    logic [`RV_XLEN-1:0] dat_w;
    logic                redirect;
    logic [`RV_XLEN-1:0] target;
} executed_t;

typedef struct packed {
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] value;
    logic                we;
    logic                redirect;
    logic [`RV_XLEN-1:0] target;
} retire_t;

typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [`RV_XLEN-1:0] adr;
    logic [`RV_XLEN-1:0] dat_w;
} wb_master_t;

endpackage

/* source/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_alu (
    input  logic [2:0]          funct3,
    input  logic                modifier,
    input  logic [`RV_XLEN-1:0] in1,
    input  logic [`RV_XLEN-1:0] in2,
    output logic [`RV_XLEN-1:0] out
);

logic [4:0] shamt;
logic       lt_signed;
logic       lt_unsigned;

assign shamt       = in2[4:0];  // RV32I shifts use only five bits.
assign lt_signed   = $signed(in1) < $signed(in2);
assign lt_unsigned = in1 < in2;

always_comb begin
    case (funct3)
        `RV_F3_ADD:  out = modifier ? in1 - in2 : in1 + in2;
        `RV_F3_SLL:  out = in1 << shamt;
        `RV_F3_SLT:  out = {{(`RV_XLEN-1){1'b0}}, lt_signed};
        `RV_F3_SLTU: out = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
        `RV_F3_XOR:  out = in1 ^ in2;
        `RV_F3_SR:   out = modifier ? $unsigned($signed(in1) >>> shamt) : in1 >> shamt;
        `RV_F3_OR:   out = in1 | in2;
        `RV_F3_AND:  out = in1 & in2;
        default:     out = '0;
    endcase
end

endmodule

/* source/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             issue_valid,
    input  rv_pkg::issue_t   issue,
    output logic             issue_ready,
    output logic             dec_valid,
    output rv_pkg::decoded_t dec,
    input  logic             dec_ready
);

import rv_pkg::*;

logic [`RV_XLEN-1:0] word;
decoded_t            next;

assign word        = issue.instr;
assign issue_ready = !dec_valid || dec_ready;  // Empty now, or emptying on this edge.

always_comb begin
    next          = '0;
    next.opcode   = word[6:0];
    next.funct3   = word[14:12];
    next.rd       = word[11:7];
    next.pc       = issue.pc;
    next.rs1_val  = issue.rs1_val;
    next.rs2_val  = issue.rs2_val;
    next.mem      = (word[6:0] == `RV_OP_LOAD) || (word[6:0] == `RV_OP_STORE);
    next.store    = (word[6:0] == `RV_OP_STORE);
    case (word[6:0])
        `RV_OP_LUI, `RV_OP_AUIPC: begin
            next.imm = {word[31:12], 12'b0};
            next.we  = 1'b1;
        end
        `RV_OP_JAL: begin
            next.imm = {{(`RV_XLEN-20){word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            next.we  = 1'b1;
        end
        `RV_OP_JALR, `RV_OP_LOAD: begin
            next.imm = {{(`RV_XLEN-12){word[31]}}, word[31:20]};
            next.we  = 1'b1;
        end
        `RV_OP_IMM: begin
            next.imm      = {{(`RV_XLEN-12){word[31]}}, word[31:20]};
            next.we       = 1'b1;
            next.modifier = (word[14:12] == `RV_F3_SR) && word[30];  // Only SRAI, never ADDI.
        end
        `RV_OP_REG: begin
            next.we       = 1'b1;
            next.modifier = word[30];
        end
        `RV_OP_STORE: next.imm = {{(`RV_XLEN-12){word[31]}}, word[31:25], word[11:7]};
        `RV_OP_BRANCH: begin
            next.imm = {{(`RV_XLEN-12){word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        end
        default: ;  // Unknown opcode retires silently.
    endcase
    if (next.rd == 5'd0) next.we = 1'b0;
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        dec_valid <= 1'b0;
    end else if (issue_ready) begin
        dec_valid <= issue_valid;
    end
end

always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) dec <= next;
end

endmodule

/* source/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dec_valid,
    input  rv_pkg::decoded_t  dec,
    output logic              dec_ready,
    output logic              ex_valid,
    output rv_pkg::executed_t ex,
    input  logic              ex_ready
);

import rv_pkg::*;

logic [`RV_XLEN-1:0] alu_in1;
logic [`RV_XLEN-1:0] alu_in2;
logic [`RV_XLEN-1:0] alu_out;
logic [2:0]          alu_funct3;
logic                alu_modifier;
logic [`RV_XLEN-1:0] rs1_plus_imm;
logic [`RV_XLEN-1:0] pc_plus_imm;
logic                taken;
logic                is_jal;
logic                is_jalr;
executed_t           next;

rv_alu i_alu (
    .funct3   (alu_funct3),
    .modifier (alu_modifier),
    .in1      (alu_in1),
    .in2      (alu_in2),
    .out      (alu_out)
);

assign dec_ready    = !ex_valid || ex_ready;
assign rs1_plus_imm = dec.rs1_val + dec.imm;
assign pc_plus_imm  = dec.pc + dec.imm;
assign is_jal       = (dec.opcode == `RV_OP_JAL);
assign is_jalr      = (dec.opcode == `RV_OP_JALR);

always_comb begin
    alu_in1      = dec.rs1_val;
    alu_in2      = dec.rs2_val;
    alu_funct3   = `RV_F3_ADD;
    alu_modifier = 1'b0;
    case (dec.opcode)
        `RV_OP_LUI: begin
            alu_in1 = dec.imm;
            alu_in2 = '0;
        end
        `RV_OP_AUIPC: begin
            alu_in1 = dec.imm;
            alu_in2 = dec.pc;
        end
        `RV_OP_JAL, `RV_OP_JALR: begin
            alu_in1 = dec.pc;
            alu_in2 = `RV_XLEN'd4;  // Link address.
        end
        `RV_OP_IMM: begin
            alu_in2      = dec.imm;
            alu_funct3   = dec.funct3;
            alu_modifier = dec.modifier;
        end
        `RV_OP_REG: begin
            alu_funct3   = dec.funct3;
            alu_modifier = dec.modifier;
        end
        `RV_OP_BRANCH: begin
            case (dec.funct3)
                `RV_F3_BEQ, `RV_F3_BNE:   alu_modifier = 1'b1;
                `RV_F3_BLT, `RV_F3_BGE:   alu_funct3   = `RV_F3_SLT;
                `RV_F3_BLTU, `RV_F3_BGEU: alu_funct3   = `RV_F3_SLTU;
                default: ;
            endcase
        end
        default: ;
    endcase
end

always_comb begin
    taken = 1'b0;
    if (dec.opcode == `RV_OP_BRANCH) begin
        case (dec.funct3)
            `RV_F3_BEQ:  taken = (alu_out == '0);
            `RV_F3_BNE:  taken = (alu_out != '0);
            `RV_F3_BLT:  taken = alu_out[0];
            `RV_F3_BGE:  taken = !alu_out[0];
            `RV_F3_BLTU: taken = alu_out[0];
            `RV_F3_BGEU: taken = !alu_out[0];
            default:     taken = 1'b0;
        endcase
    end
end

assign next.rd       = dec.rd;
assign next.value    = alu_out;
assign next.we       = dec.we;
assign next.mem      = dec.mem;
assign next.store    = dec.store;
assign next.adr      = rs1_plus_imm;
assign next.dat_w    = dec.rs2_val;
assign next.redirect = is_jal || is_jalr || taken;
assign next.target   = is_jalr ? {rs1_plus_imm[`RV_XLEN-1:1], 1'b0} : pc_plus_imm;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        ex_valid <= 1'b0;
    end else if (dec_ready) begin
        ex_valid <= dec_valid;
    end
end

always_ff @(posedge clk) begin
    if (dec_valid && dec_ready) ex <= next;
end

endmodule

/* source/rv_result.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_result (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               ex_valid,
    input  rv_pkg::executed_t  ex,
    output logic               ex_ready,
    output rv_pkg::wb_master_t wb,
    input  logic [`RV_XLEN-1:0] wb_dat_r,
    input  logic               wb_ack,
    output logic               result_valid,
    output rv_pkg::retire_t    result
);

import rv_pkg::*;

typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_RETIRE
} state_t;

state_t state;

// A new item is taken only from idle, so result_valid is always a single-cycle pulse.
assign ex_ready     = (state == ST_IDLE);
assign result_valid = (state == ST_RETIRE);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= ST_IDLE;
        wb    <= '0;
    end else begin
        case (state)
            ST_IDLE: begin
                if (ex_valid && ex.mem) begin
                    state    <= ST_BUS;
                    wb.cyc   <= 1'b1;
                    wb.stb   <= 1'b1;
                    wb.we    <= ex.store;
                    wb.adr   <= ex.adr;
                    wb.dat_w <= ex.dat_w;
                end else if (ex_valid) begin
                    state <= ST_RETIRE;
                end
            end
            ST_BUS: begin
                if (wb_ack) begin  // Cycle ends on the acknowledging edge.
                    state  <= ST_RETIRE;
                    wb.cyc <= 1'b0;
                    wb.stb <= 1'b0;
                    wb.we  <= 1'b0;
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (ex_valid && ex_ready) begin
        result.rd       <= ex.rd;
        result.value    <= ex.value;
        result.we       <= ex.we;
        result.redirect <= ex.redirect;
        result.target   <= ex.target;
    end else if (state == ST_BUS && wb_ack && !wb.we) begin
        result.value <= wb_dat_r;  // Load data is sampled at ack.
    end
end

endmodule

/* source/rv_exec_top.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_exec_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_valid,
    input  rv_pkg::issue_t      issue,
    output logic                issue_ready,
    output rv_pkg::wb_master_t  wb,
    input  logic [`RV_XLEN-1:0] wb_dat_r,
    input  logic                wb_ack,
    output logic                result_valid,
    output rv_pkg::retire_t     result
);

import rv_pkg::*;

logic      dec_valid;
logic      dec_ready;
decoded_t  dec;
logic      ex_valid;
logic      ex_ready;
executed_t ex;

rv_decode i_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue       (issue),
    .issue_ready (issue_ready),
    .dec_valid   (dec_valid),
    .dec         (dec),
    .dec_ready   (dec_ready)
);

rv_execute i_execute (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_valid (dec_valid),
    .dec       (dec),
    .dec_ready (dec_ready),
    .ex_valid  (ex_valid),
    .ex        (ex),
    .ex_ready  (ex_ready)
);

rv_result i_result (
    .clk          (clk),
    .arst_n       (arst_n),
    .ex_valid     (ex_valid),
    .ex           (ex),
    .ex_ready     (ex_ready),
    .wb           (wb),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .result_valid (result_valid),
    .result       (result)
);

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

initial clk = 1'b0;

always #2 clk = ~clk;  // 4 ns period.

initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;
end

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_checker (
    input  logic            clk,
    input  logic            result_valid,
    input  rv_pkg::retire_t result,
    output int              done_count,
    output int              fail_count
);

import rv_pkg::*;

typedef struct packed {
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] value;
    logic                we;
    logic                redirect;
    logic [`RV_XLEN-1:0] target;
    logic [1:0]          bus;      // 0 none, 1 load, 2 store.
    logic [`RV_XLEN-1:0] adr;
    logic [`RV_XLEN-1:0] dat;
} expect_t;

typedef struct packed {
    logic [`RV_XLEN-1:0] adr;
    logic                we;
    logic [`RV_XLEN-1:0] dat;
} bus_rec_t;

string    name_q[$];
expect_t  exp_q[$];
bus_rec_t bus_q[$];

initial begin
    done_count = 0;
    fail_count = 0;
end

task automatic push_expect(input string name, input logic [4:0] rd,
                           input logic [`RV_XLEN-1:0] value, input logic we,
                           input logic redirect, input logic [`RV_XLEN-1:0] target,
                           input logic [1:0] bus, input logic [`RV_XLEN-1:0] adr,
                           input logic [`RV_XLEN-1:0] dat);
    expect_t e;
    e.rd       = rd;
    e.value    = value;
    e.we       = we;
    e.redirect = redirect;
    e.target   = target;
    e.bus      = bus;
    e.adr      = adr;
    e.dat      = dat;
    name_q.push_back(name);
    exp_q.push_back(e);
endtask

task automatic record_bus(input logic [`RV_XLEN-1:0] adr, input logic we,
                          input logic [`RV_XLEN-1:0] dat);
    bus_q.push_back('{adr: adr, we: we, dat: dat});
endtask

task automatic check_field(input string name, input string field,
                           input logic [`RV_XLEN-1:0] exp_val,
                           input logic [`RV_XLEN-1:0] act_val, inout bit bad);
    if (exp_val !== act_val) begin
        $display("** Error test %s %s: expected %h actual %h", name, field, exp_val, act_val);
        bad = 1'b1;
    end
endtask

task automatic report_counts();
    $display("Tests run %0d, passed %0d, failed %0d",
             done_count, done_count - fail_count, fail_count);
endtask

always @(negedge clk) begin : check_result
    string    name;
    expect_t  e;
    bus_rec_t b;
    bit       bad;
    if (result_valid) begin
        if (exp_q.size() == 0) begin
            $display("A result retired with no test waiting for it");
            fail_count = fail_count + 1;
        end else begin
            name = name_q.pop_front();
            e    = exp_q.pop_front();
            bad  = 1'b0;
            check_field(name, "we", {31'b0, e.we}, {31'b0, result.we}, bad);
            check_field(name, "redirect", {31'b0, e.redirect}, {31'b0, result.redirect}, bad);
            if (e.we) begin
                check_field(name, "rd", {27'b0, e.rd}, {27'b0, result.rd}, bad);
                check_field(name, "value", e.value, result.value, bad);
            end
            if (e.redirect) check_field(name, "target", e.target, result.target, bad);
            if (e.bus != 2'd0) begin
                if (bus_q.size() == 0) begin
                    $display("Test %s retired without any Wishbone cycle on the bus", name);
                    bad = 1'b1;
                end else begin
                    b = bus_q.pop_front();
                    check_field(name, "bus adr", e.adr, b.adr, bad);
                    check_field(name, "bus we", {31'b0, e.bus == 2'd2}, {31'b0, b.we}, bad);
                    if (e.bus == 2'd2) check_field(name, "bus dat_w", e.dat, b.dat, bad);
                end
            end
            $display("Test %s %s", name, bad ? "failed" : "passed");
            if (bad) fail_count = fail_count + 1;
            done_count = done_count + 1;
        end
    end
end

endmodule

/* testbench/rv_exec_properties.sv */
`timescale 1ns/1ps

module rv_exec_properties (
    input logic               clk,
    input logic               arst_n,
    input rv_pkg::wb_master_t wb,
    input logic               wb_ack,
    input logic               result_valid
);

int assert_fails = 0;

a_stb_needs_cyc: assert property (@(posedge clk) disable iff (!arst_n) wb.stb |-> wb.cyc)
    else begin
        $error("stb high without cyc");
        assert_fails++;
    end

// Request must hold until the slave acknowledges.
a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (wb.stb && !wb_ack) |=> ($stable(wb.adr) && $stable(wb.we) && $stable(wb.dat_w)))
    else begin
        $error("Wishbone request changed before ack");
        assert_fails++;
    end

a_result_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid |=> !result_valid)
    else begin
        $error("result_valid high for two cycles");
        assert_fails++;
    end

a_reset_quiet: assert property (@(posedge clk) !arst_n |-> (!result_valid && !wb.cyc && !wb.stb))
    else begin
        $error("Output active during reset");
        assert_fails++;
    end

endmodule

bind rv_result rv_exec_properties i_props (
    .clk          (clk),
    .arst_n       (arst_n),
    .wb           (wb),
    .wb_ack       (wb_ack),
    .result_valid (result_valid)
);

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_top;

import rv_pkg::*;

logic                clk;
logic                arst_n;
logic                issue_valid;
issue_t              issue;
logic                issue_ready;
wb_master_t          wb;
logic [`RV_XLEN-1:0] wb_dat_r;
logic                wb_ack;
logic                result_valid;
retire_t             result;
int                  done_count;
int                  fail_count;

string               names[$];
issue_t              issues[$];
logic [`RV_XLEN-1:0] load_q[$];   // Data the memory returns, in load order.
int                  n_tests;
int                  wait_cycles;
logic                busy;

tb_clock i_clock (
    .clk    (clk),
    .arst_n (arst_n)
);

rv_exec_top i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .issue_ready  (issue_ready),
    .wb           (wb),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .result_valid (result_valid),
    .result       (result)
);

tb_checker i_checker (
    .clk          (clk),
    .result_valid (result_valid),
    .result       (result),
    .done_count   (done_count),
    .fail_count   (fail_count)
);

task automatic read_patterns();
    int                  fd;
    string               line;
    string               name;
    logic [`RV_XLEN-1:0] v [0:12];
    fd = $fopen("testbench/exec_patterns.txt", "r");
    if (fd == 0) begin
        $display("Could not open the pattern file");
        return;
    end
    while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue;
        if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name, v[0], v[1], v[2],
                    v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], v[12]) != 14) begin
            continue;
        end
        names.push_back(name);
        issues.push_back('{instr: v[0], pc: v[1], rs1_val: v[2], rs2_val: v[3]});
        if (v[10][1:0] == 2'd1) load_q.push_back(v[4]);
        i_checker.push_expect(name, v[5][4:0], v[6], v[7][0], v[8][0], v[9], v[10][1:0],
                              v[11], v[12]);
    end
    $fclose(fd);
    n_tests = names.size();
endtask

// Wishbone memory with 0 to 3 wait cycles per access.
initial begin
    void'($urandom(19));
    forever begin
        @(posedge clk);
        #1;
        if (wb_ack) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb.cyc && wb.stb) begin
            if (!busy) begin
                busy        = 1'b1;
                wait_cycles = $urandom_range(3, 0);
            end
            if (wait_cycles == 0) begin
                wb_ack   = 1'b1;
                wb_dat_r = (!wb.we && load_q.size() > 0) ? load_q.pop_front() : '0;
                i_checker.record_bus(wb.adr, wb.we, wb.dat_w);
            end else begin
                wait_cycles = wait_cycles - 1;
            end
        end
    end
end

initial begin
    issue_valid = 1'b0;
    issue       = '0;
    wb_ack      = 1'b0;
    wb_dat_r    = '0;
    busy        = 1'b0;
    wait_cycles = 0;
    n_tests     = 0;
    read_patterns();
    wait (arst_n);
    @(posedge clk);
    #1;
    for (int k = 0; k < n_tests; k++) begin
        issue       = issues[k];
        issue_valid = 1'b1;
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        @(posedge clk);
        #1;
    end
    issue_valid = 1'b0;
    wait (done_count == n_tests);
    repeat (2) @(negedge clk);
    i_checker.report_counts();
    if (fail_count == 0 && n_tests > 0 && i_dut.i_result.i_props.assert_fails == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

initial begin
    wait (n_tests > 0);
    #(n_tests * 20 * 4 + 10 * 4);
    $display("Timeout: only %0d of %0d tests retired in time", done_count, n_tests);
    $display("TB FAILED");
    $finish;
end

endmodule

/* testbench/exec_patterns.txt */
# name instr pc rs1 rs2 load_data | exp: rd value we redirect target bus(0 none,1 ld,2 st) adr sdat
# All columns hex.
add      002081B3 00000000 00000005 00000007 0 3 0000000C 1 0 0 0 0 0
sub      402081B3 00000000 00000005 00000007 0 3 FFFFFFFE 1 0 0 0 0 0
sll      002091B3 00000000 80000010 00000024 0 3 00000100 1 0 0 0 0 0
slt_neg  0020A1B3 00000000 FFFFFFFF 00000001 0 3 00000001 1 0 0 0 0 0
sltu_neg 0020B1B3 00000000 FFFFFFFF 00000001 0 3 00000000 1 0 0 0 0 0
xor      0020C1B3 00000000 F0F0F0F0 0FF00FF0 0 3 FF00FF00 1 0 0 0 0 0
srl      0020D1B3 00000000 80000010 00000024 0 3 08000001 1 0 0 0 0 0
sra      4020D1B3 00000000 80000010 00000024 0 3 F8000001 1 0 0 0 0 0
or       0020E1B3 00000000 0000F000 000000F0 0 3 0000F0F0 1 0 0 0 0 0
and      0020F1B3 00000000 FF00FF00 0FF00FF0 0 3 0F000F00 1 0 0 0 0 0
addi_neg FFD08193 00000000 0000000A 00000000 0 3 00000007 1 0 0 0 0 0
srai     4040D193 00000000 80000000 00000000 0 3 F8000000 1 0 0 0 0 0
srli     0040D193 00000000 80000000 00000000 0 3 08000000 1 0 0 0 0 0
andi     0F00F193 00000000 12345678 00000000 0 3 00000070 1 0 0 0 0 0
lui      123452B7 00000000 00000000 00000000 0 5 12345000 1 0 0 0 0 0
auipc    00001317 00000100 00000000 00000000 0 6 00001100 1 0 0 0 0 0
lui_x0   12345037 00000000 00000000 00000000 0 0 12345000 0 0 0 0 0 0
beq_t    00208463 00000200 00000005 00000005 0 0 0 0 1 00000208 0 0 0
beq_nt   00208463 00000200 00000005 00000006 0 0 0 0 0 0 0 0 0
bne_t    00209463 00000200 00000005 00000006 0 0 0 0 1 00000208 0 0 0
bne_nt   00209463 00000200 00000005 00000005 0 0 0 0 0 0 0 0 0
blt_t    0020C463 00000200 FFFFFFFF 00000001 0 0 0 0 1 00000208 0 0 0
blt_nt   0020C463 00000200 00000001 FFFFFFFF 0 0 0 0 0 0 0 0 0
bge_t    0020D463 00000200 00000003 00000003 0 0 0 0 1 00000208 0 0 0
bge_nt   0020D463 00000200 FFFFFFFF 00000001 0 0 0 0 0 0 0 0 0
bltu_t   0020E463 00000200 00000001 FFFFFFFF 0 0 0 0 1 00000208 0 0 0
bltu_nt  0020E463 00000200 FFFFFFFF 00000001 0 0 0 0 0 0 0 0 0
bgeu_t   0020F463 00000200 FFFFFFFF 00000001 0 0 0 0 1 00000208 0 0 0
bgeu_nt  0020F463 00000200 00000001 FFFFFFFF 0 0 0 0 0 0 0 0 0
jal      010000EF 00000300 00000000 00000000 0 1 00000304 1 1 00000310 0 0 0
jalr     005100E7 00000400 00001000 00000000 0 1 00000404 1 1 00001004 0 0 0
pre_ld   002081B3 00000000 00000001 00000002 0 3 00000003 1 0 0 0 0 0
lw       0080A383 00000000 00002000 00000000 DEADBEEF 7 DEADBEEF 1 0 0 1 00002008 0
post_ld  002081B3 00000000 00000004 00000005 0 3 00000009 1 0 0 0 0 0
lw_neg   FFC0A383 00000000 00002010 00000000 0BADF00D 7 0BADF00D 1 0 0 1 0000200C 0
sw       0020A623 00000000 00003000 CAFEF00D 0 0 0 0 0 0 2 0000300C CAFEF00D
add_end  002081B3 00000000 00000010 00000020 0 3 00000030 1 0 0 0 0 0

/* sim.f */
+incdir+source
source/rv_pkg.sv
source/rv_alu.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_exec_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/rv_exec_properties.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute slice testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_top -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    exit 1
fi
